//--- cu_ctrl.f
+incdir+tests
design/isa_pkg.sv
design/ctrl_pkg.sv
design/instr_decode.sv
design/ctrl_execute.sv
design/branch_resolve.sv
design/cu_top.sv
tests/cu_sva.sv
tests/cu_tb.sv

//--- Bender.yml
package:
  name: cu_ctrl

sources:
  - files:
      - design/isa_pkg.sv
      - design/ctrl_pkg.sv
      - design/instr_decode.sv
      - design/ctrl_execute.sv
      - design/branch_resolve.sv
      - design/cu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cu_sva.sv
      - tests/cu_tb.sv

//--- tests/cu_tb_tasks.svh
// Expected words, built from the instruction table
function automatic ctrl_pkg::ctrl_word_t idle_word(input isa_pkg::alu_op_t op);
	ctrl_pkg::ctrl_word_t w;
	w = '0; // Every select at its zero code, PC plus one
	w.alu_op = op;
	return w;
endfunction

function automatic ctrl_pkg::ctrl_word_t reg_write_word(input isa_pkg::alu_op_t op,
	input ctrl_pkg::wb_addr_t addr);
	ctrl_pkg::ctrl_word_t w;
	w = idle_word(op);
	w.alu_out = 1'b1;
	w.wb_src = ctrl_pkg::wb_src_alu_or_mem;
	w.wb_addr = addr;
	w.regf_we = 1'b1;
	return w;
endfunction

function automatic isa_pkg::flags_t random_flags();
	return isa_pkg::flags_t'($random(seed));
endfunction

function automatic isa_pkg::instr_byte_t random_byte();
	return isa_pkg::instr_byte_t'($random(seed));
endfunction

task automatic check_ctrl(input string name, input ctrl_pkg::ctrl_word_t exp,
	input ctrl_pkg::ctrl_word_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
	end
endtask

task automatic check_alu(input string name, input isa_pkg::alu_op_t exp,
	input isa_pkg::alu_op_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
	end
endtask

// Inputs change on the falling edge, outputs settle well before the rising edge
task automatic drive_byte(input isa_pkg::instr_byte_t b, input isa_pkg::flags_t f);
	@(negedge clk);
	opcode = b;
	flags = f;
	#1;
endtask

task automatic drive_and_check(input isa_pkg::instr_byte_t b, input isa_pkg::flags_t f,
	input ctrl_pkg::ctrl_word_t exp);
	drive_byte(b, f);
	check_ctrl($sformatf("ctrl for byte %h", b), exp, ctrl);
endtask

// NOP bytes until an idle word shows that the next cycle is a first byte
task automatic wait_first_phase();
	int n;
	if (wait_timed_out)
		return;
	for (n = 0; n < 8; n++) begin
		drive_byte(8'h00, 4'h0);
		if (ctrl.alu_op == isa_pkg::aop_nop && ctrl.pc_sel == ctrl_pkg::pc_plus1 && !stall_2byte)
			return;
	end
	wait_timed_out = 1'b1;
	errors++;
	$display("Timeout: the DUT did not reach the first-byte phase within 8 cycles");
endtask

task automatic test_reset();
	ctrl_pkg::ctrl_word_t reset_word;
	int n;
	reset_word = idle_word(isa_pkg::aop_nop);
	reset_word.pc_sel = ctrl_pkg::pc_reset_vec;
	for (n = 0; n < 2; n++) begin
		drive_byte(8'hC0, random_flags()); // TWO byte, must not stall
		check_ctrl("ctrl in reset", reset_word, ctrl);
		check_bit("stall_2byte in reset", 1'b0, stall_2byte);
	end
	@(negedge clk);
	rst = 1'b1; // Third rising edge of reset has passed
	#1;
	check_ctrl("ctrl in boot cycle", reset_word, ctrl);
	check_bit("stall_2byte in boot cycle", 1'b0, stall_2byte);
	drive_and_check(8'h00, random_flags(), idle_word(isa_pkg::aop_nop));
endtask

task automatic test_alu_ops();
	isa_pkg::instr_byte_t b;
	ctrl_pkg::ctrl_word_t exp;
	int g;
	int lo;
	for (g = 1; g <= 8; g++) begin
		for (lo = 0; lo < 16 && g != 7; lo++) begin
			b = {g[3:0], lo[3:0]};
			case (b[7:4])
				4'h1: exp = reg_write_word(isa_pkg::aop_mov, ctrl_pkg::wa_ra);
				4'h2: exp = reg_write_word(isa_pkg::aop_add, ctrl_pkg::wa_ra);
				4'h3: exp = reg_write_word(isa_pkg::aop_sub, ctrl_pkg::wa_ra);
				4'h4: exp = reg_write_word(isa_pkg::aop_and, ctrl_pkg::wa_ra);
				4'h5: exp = reg_write_word(isa_pkg::aop_or, ctrl_pkg::wa_ra);
				4'h6: case (b[3:2])
					2'd0:    exp = reg_write_word(isa_pkg::aop_rlc, ctrl_pkg::wa_rb);
					2'd1:    exp = reg_write_word(isa_pkg::aop_rrc, ctrl_pkg::wa_rb);
					2'd2:    exp = idle_word(isa_pkg::aop_setc); // Carry flag only
					default: exp = idle_word(isa_pkg::aop_clrc);
				endcase
				default: case (b[3:2])
					2'd0:    exp = reg_write_word(isa_pkg::aop_not, ctrl_pkg::wa_rb);
					2'd1:    exp = reg_write_word(isa_pkg::aop_neg, ctrl_pkg::wa_rb);
					2'd2:    exp = reg_write_word(isa_pkg::aop_inc, ctrl_pkg::wa_rb);
					default: exp = reg_write_word(isa_pkg::aop_dec, ctrl_pkg::wa_rb);
				endcase
			endcase
			drive_and_check(b, random_flags(), exp);
		end
	end
endtask

task automatic test_mem_stack();
	ctrl_pkg::ctrl_word_t exp;
	isa_pkg::reg_idx_t r;
	int i;
	for (i = 0; i < 4; i++) begin
		r = i[1:0];
		exp = idle_word(isa_pkg::aop_push);
		exp.dmem_addr = ctrl_pkg::da_sp;
		exp.dmem_wd = ctrl_pkg::wd_rb;
		exp.dmem_we = 1'b1;
		drive_and_check({4'h7, 2'd0, r}, random_flags(), exp);
		exp = reg_write_word(isa_pkg::aop_pop, ctrl_pkg::wa_rb);
		exp.alu_out = 1'b0;
		exp.dmem_addr = ctrl_pkg::da_sp_pre_inc;
		exp.dmem_re = 1'b1;
		exp.sp_inc = 1'b1;
		drive_and_check({4'h7, 2'd1, r}, random_flags(), exp);
		exp = idle_word(isa_pkg::aop_out);
		exp.out_port_en = 1'b1;
		drive_and_check({4'h7, 2'd2, r}, random_flags(), exp);
		exp = reg_write_word(isa_pkg::aop_in, ctrl_pkg::wa_rb);
		exp.wb_src = ctrl_pkg::wb_src_in_port;
		drive_and_check({4'h7, 2'd3, r}, random_flags(), exp);
		exp = reg_write_word(isa_pkg::aop_ldi, ctrl_pkg::wa_rb);
		exp.alu_out = 1'b0;
		exp.dmem_addr = ctrl_pkg::da_ra;
		exp.dmem_re = 1'b1;
		drive_and_check({4'hD, ~r, r}, random_flags(), exp);
		exp = idle_word(isa_pkg::aop_sti);
		exp.dmem_addr = ctrl_pkg::da_ra;
		exp.dmem_wd = ctrl_pkg::wd_rb;
		exp.dmem_we = 1'b1;
		drive_and_check({4'hE, ~r, r}, random_flags(), exp);
		exp = idle_word(isa_pkg::aop_call);
		exp.alu_out = 1'b1;
		exp.dmem_addr = ctrl_pkg::da_sp;
		exp.dmem_wd = ctrl_pkg::wd_pc_next; // Return address onto the stack
		exp.dmem_we = 1'b1;
		exp.wb_src = ctrl_pkg::wb_src_sp;
		exp.wb_addr = ctrl_pkg::wa_sp;
		exp.regf_we = 1'b1;
		exp.pc_sel = ctrl_pkg::pc_target;
		exp.branch_taken = 1'b1;
		drive_and_check({4'hB, 2'd1, r}, random_flags(), exp);
		exp = idle_word(isa_pkg::aop_ret);
		exp.dmem_addr = ctrl_pkg::da_sp_pre_inc;
		exp.dmem_re = 1'b1;
		exp.sp_inc = 1'b1;
		exp.wb_src = ctrl_pkg::wb_src_sp;
		exp.wb_addr = ctrl_pkg::wa_sp;
		exp.regf_we = 1'b1;
		exp.is_ret = 1'b1;
		exp.pc_sel = ctrl_pkg::pc_target; // Target without branch_taken
		drive_and_check({4'hB, 2'd2, r}, random_flags(), exp);
	end
endtask

task automatic test_cond_branch();
	ctrl_pkg::ctrl_word_t exp;
	isa_pkg::flags_t f;
	isa_pkg::sub_op_t s;
	isa_pkg::alu_op_t op;
	int i;
	int n;
	for (i = 0; i < 4; i++) begin
		s = i[1:0];
		case (s)
			isa_pkg::flag_z: op = isa_pkg::aop_jz;
			isa_pkg::flag_n: op = isa_pkg::aop_jn;
			isa_pkg::flag_c: op = isa_pkg::aop_jc;
			default:         op = isa_pkg::aop_jv;
		endcase
		for (n = 0; n < 16; n++) begin
			f = random_flags();
			exp = idle_word(op);
			if (f[s]) begin
				exp.alu_op = isa_pkg::aop_pass;
				exp.alu_out = 1'b1;
				exp.pc_sel = ctrl_pkg::pc_target;
				exp.branch_taken = 1'b1;
			end
			drive_and_check({4'h9, s, n[1:0]}, f, exp);
			check_bit("branch_taken on conditional branch", f[s], ctrl.branch_taken);
		end
	end
endtask

task automatic test_two_byte();
	ctrl_pkg::ctrl_word_t exp;
	int i;
	int r;
	for (i = 0; i < 3; i++) begin
		for (r = 0; r < 4; r++) begin
			drive_byte({4'hC, i[1:0], r[1:0]}, random_flags());
			check_bit("stall_2byte on first byte", 1'b1, stall_2byte);
			check_ctrl("ctrl on first byte", idle_word(isa_pkg::aop_nop), ctrl);
			case (i)
				0: begin
					exp = reg_write_word(isa_pkg::aop_ldm, ctrl_pkg::wa_old_rb);
					exp.wb_src = ctrl_pkg::wb_src_imm;
				end
				1: begin
					exp = reg_write_word(isa_pkg::aop_ldd, ctrl_pkg::wa_old_rb);
					exp.alu_out = 1'b0;
					exp.dmem_addr = ctrl_pkg::da_ea;
					exp.dmem_re = 1'b1;
				end
				default: begin
					exp = idle_word(isa_pkg::aop_std);
					exp.dmem_addr = ctrl_pkg::da_ea;
					exp.dmem_wd = ctrl_pkg::wd_rb;
					exp.dmem_we = 1'b1;
					exp.rd2_old_rb = 1'b1;
				end
			endcase
			exp.old_rb = r[1:0];
			drive_and_check(random_byte(), random_flags(), exp);
			check_bit("stall_2byte on second byte", 1'b0, stall_2byte);
		end
	end
endtask

task automatic test_loop();
	ctrl_pkg::ctrl_word_t exp;
	isa_pkg::instr_byte_t b;
	isa_pkg::flags_t f;
	int n;
	for (n = 0; n < 8; n++) begin
		b = random_byte();
		b[7:4] = 4'hA;
		f = random_flags();
		f[isa_pkg::flag_z] = n[0]; // Both outcomes in turn
		drive_byte(b, f);
		check_alu("alu_op on LOOP byte", isa_pkg::aop_loop, ctrl.alu_op);
		check_bit("branch_taken on LOOP byte", ~f[isa_pkg::flag_z], ctrl.branch_taken);
		exp = idle_word(isa_pkg::aop_loop);
		if (!f[isa_pkg::flag_z]) begin
			exp.pc_sel = ctrl_pkg::pc_target;
			exp.branch_taken = 1'b1;
		end
		check_ctrl("ctrl on LOOP byte", exp, ctrl);
		drive_and_check(random_byte(), random_flags(),
			reg_write_word(isa_pkg::aop_loop, ctrl_pkg::wa_ra));
		drive_and_check({4'h1, b[3:0]}, random_flags(),
			reg_write_word(isa_pkg::aop_mov, ctrl_pkg::wa_ra));
	end
endtask

//--- tests/cu_tb.sv
`timescale 1ns/1ps

module cu_tb;

	logic                 clk;
	logic                 rst;
	isa_pkg::instr_byte_t opcode;
	isa_pkg::flags_t      flags;
	ctrl_pkg::ctrl_word_t ctrl;
	logic                 stall_2byte;

	integer seed;
	int     checks;
	int     errors;
	logic   wait_timed_out;  // A phase wait ran out of cycles

	cu_top dut (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.flags       (flags),
		.ctrl        (ctrl),
		.stall_2byte (stall_2byte)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	`include "cu_tb_tasks.svh"

	initial begin
		rst = 1'b0;
		opcode = 8'h00;
		flags = 4'h0;
		seed = 32'h05b794e4;
		checks = 0;
		errors = 0;
		wait_timed_out = 1'b0;

		test_reset();
		wait_first_phase();
		if (!wait_timed_out)
			test_alu_ops();
		wait_first_phase();
		if (!wait_timed_out)
			test_mem_stack();
		wait_first_phase();
		if (!wait_timed_out)
			test_cond_branch();
		wait_first_phase();
		if (!wait_timed_out)
			test_two_byte();
		wait_first_phase();
		if (!wait_timed_out)
			test_loop();

		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, dut.u_sva.fail_count);
		if (errors == 0 && dut.u_sva.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tests/cu_sva.sv
`timescale 1ns/1ps

module cu_sva (
	input logic                 clk,
	input logic                 rst,
	input ctrl_pkg::ctrl_word_t ctrl,
	input logic                 stall_2byte
);

	int fail_count;

	initial fail_count = 0;

	// One memory access direction per cycle
	mem_one_dir: assert property (@(posedge clk) disable iff (!rst)
		!(ctrl.dmem_we && ctrl.dmem_re))
		else begin
			$error("dmem_we and dmem_re high in the same cycle");
			fail_count++;
		end

	stall_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		stall_2byte |=> !stall_2byte)
		else begin
			$error("stall_2byte high in two cycles in a row");
			fail_count++;
		end

	pop_reads_mem: assert property (@(posedge clk) disable iff (!rst)
		ctrl.sp_inc |-> ctrl.dmem_re)
		else begin
			$error("sp_inc without a data memory read");
			fail_count++;
		end

endmodule

bind cu_top cu_sva u_sva (
	.clk         (clk),
	.rst         (rst),
	.ctrl        (ctrl),
	.stall_2byte (stall_2byte)
);

//--- design/cu_top.sv
`timescale 1ns/1ps

module cu_top (
	input  logic                 clk,
	input  logic                 rst,
	input  isa_pkg::instr_byte_t opcode,
	input  isa_pkg::flags_t      flags,
	output ctrl_pkg::ctrl_word_t ctrl,
	output logic                 stall_2byte
);

	ctrl_pkg::decoded_t   dec;
	ctrl_pkg::ctrl_word_t base;  // Word before the branch decision

	instr_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.dec         (dec),
		.stall_2byte (stall_2byte)
	);

	ctrl_execute u_execute (
		.dec  (dec),
		.base (base)
	);

	branch_resolve u_branch (
		.dec   (dec),
		.base  (base),
		.flags (flags),
		.ctrl  (ctrl)
	);

endmodule

//--- design/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
	input  ctrl_pkg::decoded_t   dec,
	input  ctrl_pkg::ctrl_word_t base,
	input  isa_pkg::flags_t      flags,
	output ctrl_pkg::ctrl_word_t ctrl
);

	logic taken;

	always_comb begin
		case (dec.br_kind)
			ctrl_pkg::br_cond:   taken = flags[dec.sub_op]; // Sub-op picks the flag
			ctrl_pkg::br_always: taken = 1'b1;
			ctrl_pkg::br_loop:   taken = ~flags[isa_pkg::flag_z]; // Counter not yet zero
			default:             taken = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = base;

		// Return address comes from memory, not a taken branch
		if (dec.br_kind == ctrl_pkg::br_return)
			ctrl.pc_sel = ctrl_pkg::pc_target;

		if (taken) begin
			ctrl.pc_sel = ctrl_pkg::pc_target;
			ctrl.branch_taken = 1'b1;
			if (dec.br_kind == ctrl_pkg::br_cond) begin
				ctrl.alu_op = isa_pkg::aop_pass; // Pass R[rb] as target
				ctrl.alu_out = 1'b1;
			end
		end
	end

endmodule

//--- design/ctrl_execute.sv
`timescale 1ns/1ps

module ctrl_execute (
	input  ctrl_pkg::decoded_t   dec,
	output ctrl_pkg::ctrl_word_t base
);

	// Result of the ALU goes to the register file
	function automatic ctrl_pkg::ctrl_word_t alu_wb(
		input ctrl_pkg::ctrl_word_t w,
		input isa_pkg::alu_op_t     op,
		input ctrl_pkg::wb_addr_t   addr
	);
		ctrl_pkg::ctrl_word_t r;
		r = w;
		r.alu_op = op;
		r.alu_out = 1'b1;
		r.wb_src = ctrl_pkg::wb_src_alu_or_mem;
		r.wb_addr = addr;
		r.regf_we = 1'b1;
		return r;
	endfunction

	always_comb begin
		base = ctrl_pkg::ctrl_nop;
		base.old_rb = dec.old_rb;
		case (dec.phase)
			ctrl_pkg::ph_boot: begin
				base = ctrl_pkg::ctrl_nop;
				base.pc_sel = ctrl_pkg::pc_reset_vec; // Fetch from the reset vector
			end

			ctrl_pkg::ph_loop_wb: begin
				base = alu_wb(base, isa_pkg::aop_loop, ctrl_pkg::wa_ra); // Decremented counter
			end

			ctrl_pkg::ph_second: begin
				case (dec.sub_op)
					isa_pkg::sub_ldm: begin
						base = alu_wb(base, isa_pkg::aop_ldm, ctrl_pkg::wa_old_rb);
						base.wb_src = ctrl_pkg::wb_src_imm;
					end
					isa_pkg::sub_ldd: begin
						base = alu_wb(base, isa_pkg::aop_ldd, ctrl_pkg::wa_old_rb);
						base.alu_out = 1'b0; // Memory data
						base.dmem_addr = ctrl_pkg::da_ea;
						base.dmem_re = 1'b1;
					end
					isa_pkg::sub_std: begin
						base.alu_op = isa_pkg::aop_std;
						base.dmem_addr = ctrl_pkg::da_ea;
						base.dmem_wd = ctrl_pkg::wd_rb;
						base.dmem_we = 1'b1;
						base.rd2_old_rb = 1'b1; // Read port 2 takes old_rb
					end
					default: base.alu_op = isa_pkg::aop_nop;
				endcase
			end

			default: begin
				case (dec.group)
					isa_pkg::op_mov: base = alu_wb(base, isa_pkg::aop_mov, ctrl_pkg::wa_ra);
					isa_pkg::op_add: base = alu_wb(base, isa_pkg::aop_add, ctrl_pkg::wa_ra);
					isa_pkg::op_sub: base = alu_wb(base, isa_pkg::aop_sub, ctrl_pkg::wa_ra);
					isa_pkg::op_and: base = alu_wb(base, isa_pkg::aop_and, ctrl_pkg::wa_ra);
					isa_pkg::op_or:  base = alu_wb(base, isa_pkg::aop_or, ctrl_pkg::wa_ra);

					isa_pkg::op_rot: begin
						case (dec.sub_op)
							isa_pkg::sub_rlc:  base = alu_wb(base, isa_pkg::aop_rlc, ctrl_pkg::wa_rb);
							isa_pkg::sub_rrc:  base = alu_wb(base, isa_pkg::aop_rrc, ctrl_pkg::wa_rb);
							isa_pkg::sub_setc: base.alu_op = isa_pkg::aop_setc; // Carry only
							default:           base.alu_op = isa_pkg::aop_clrc;
						endcase
					end

					isa_pkg::op_stk: begin
						case (dec.sub_op)
							isa_pkg::sub_push: begin
								base.alu_op = isa_pkg::aop_push;
								base.dmem_addr = ctrl_pkg::da_sp; // Post-decrement
								base.dmem_wd = ctrl_pkg::wd_rb;
								base.dmem_we = 1'b1;
							end
							isa_pkg::sub_pop: begin
								base = alu_wb(base, isa_pkg::aop_pop, ctrl_pkg::wa_rb);
								base.alu_out = 1'b0;
								base.dmem_addr = ctrl_pkg::da_sp_pre_inc;
								base.dmem_re = 1'b1;
								base.sp_inc = 1'b1;
							end
							isa_pkg::sub_out: begin
								base.alu_op = isa_pkg::aop_out;
								base.out_port_en = 1'b1;
							end
							default: begin
								base = alu_wb(base, isa_pkg::aop_in, ctrl_pkg::wa_rb);
								base.wb_src = ctrl_pkg::wb_src_in_port;
							end
						endcase
					end

					isa_pkg::op_una: begin
						case (dec.sub_op)
							isa_pkg::sub_not: base = alu_wb(base, isa_pkg::aop_not, ctrl_pkg::wa_rb);
							isa_pkg::sub_neg: base = alu_wb(base, isa_pkg::aop_neg, ctrl_pkg::wa_rb);
							isa_pkg::sub_inc: base = alu_wb(base, isa_pkg::aop_inc, ctrl_pkg::wa_rb);
							default:          base = alu_wb(base, isa_pkg::aop_dec, ctrl_pkg::wa_rb);
						endcase
					end

					isa_pkg::op_brc: begin
						case (dec.sub_op)
							isa_pkg::flag_z: base.alu_op = isa_pkg::aop_jz;
							isa_pkg::flag_n: base.alu_op = isa_pkg::aop_jn;
							isa_pkg::flag_c: base.alu_op = isa_pkg::aop_jc;
							isa_pkg::flag_v: base.alu_op = isa_pkg::aop_jv;
							default:         base.alu_op = isa_pkg::aop_nop;
						endcase
					end

					isa_pkg::op_loop: base.alu_op = isa_pkg::aop_loop; // Write back follows

					isa_pkg::op_jmp: begin
						case (dec.sub_op)
							isa_pkg::sub_jmp: begin
								base.alu_op = isa_pkg::aop_pass; // Target is R[rb]
								base.alu_out = 1'b1;
							end
							isa_pkg::sub_call: begin
								base.alu_op = isa_pkg::aop_call;
								base.alu_out = 1'b1;
								base.dmem_addr = ctrl_pkg::da_sp;
								base.dmem_wd = ctrl_pkg::wd_pc_next; // Return address
								base.dmem_we = 1'b1;
								base.wb_src = ctrl_pkg::wb_src_sp;
								base.wb_addr = ctrl_pkg::wa_sp;
								base.regf_we = 1'b1;
							end
							isa_pkg::sub_ret: begin
								base.alu_op = isa_pkg::aop_ret;
								base.dmem_addr = ctrl_pkg::da_sp_pre_inc;
								base.dmem_re = 1'b1;
								base.sp_inc = 1'b1;
								base.wb_src = ctrl_pkg::wb_src_sp;
								base.wb_addr = ctrl_pkg::wa_sp;
								base.regf_we = 1'b1;
								base.is_ret = 1'b1;
							end
							default: base.alu_op = isa_pkg::aop_nop;
						endcase
					end

					isa_pkg::op_ldi: begin
						base = alu_wb(base, isa_pkg::aop_ldi, ctrl_pkg::wa_rb);
						base.alu_out = 1'b0;
						base.dmem_addr = ctrl_pkg::da_ra; // Address R[ra]
						base.dmem_re = 1'b1;
					end

					isa_pkg::op_sti: begin
						base.alu_op = isa_pkg::aop_sti;
						base.dmem_addr = ctrl_pkg::da_ra;
						base.dmem_wd = ctrl_pkg::wd_rb;
						base.dmem_we = 1'b1;
					end

					// NOP, first byte of TWO and the reserved group
					default: base.alu_op = isa_pkg::aop_nop;
				endcase
			end
		endcase
	end

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                 clk,
	input  logic                 rst,
	input  isa_pkg::instr_byte_t opcode,
	output ctrl_pkg::decoded_t   dec,
	output logic                 stall_2byte
);

	ctrl_pkg::phase_t     phase;
	ctrl_pkg::phase_t     phase_next;
	isa_pkg::instr_byte_t first_byte;  // Byte taken in the last FIRST cycle
	isa_pkg::instr_byte_t cur_byte;    // Byte the fields come from
	isa_pkg::opcode_t     live_group;

	assign live_group = isa_pkg::opcode_t'(opcode[7:4]);
	assign stall_2byte = (phase == ctrl_pkg::ph_first) && (live_group == isa_pkg::op_two);

	// Second byte and loop write back refer to the stored byte
	assign cur_byte = (phase == ctrl_pkg::ph_second || phase == ctrl_pkg::ph_loop_wb) ?
		first_byte : opcode;

	always_comb begin
		case (phase)
			ctrl_pkg::ph_first: begin
				if (live_group == isa_pkg::op_two)
					phase_next = ctrl_pkg::ph_second;
				else if (live_group == isa_pkg::op_loop)
					phase_next = ctrl_pkg::ph_loop_wb;
				else
					phase_next = ctrl_pkg::ph_first;
			end
			default: phase_next = ctrl_pkg::ph_first; // BOOT, SECOND, LOOP_WB last one cycle
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			phase <= ctrl_pkg::ph_boot;
		else
			phase <= phase_next;
	end

	always_ff @(posedge clk) begin
		if (phase == ctrl_pkg::ph_first)
			first_byte <= opcode;
	end

	always_comb begin
		dec.phase = phase;
		dec.group = isa_pkg::opcode_t'(cur_byte[7:4]);
		dec.sub_op = cur_byte[3:2];
		dec.ra = cur_byte[3:2];
		dec.rb = cur_byte[1:0];
		dec.old_rb = (phase == ctrl_pkg::ph_second) ? first_byte[1:0] : 2'b00;

		// Only a live first byte can branch
		dec.br_kind = ctrl_pkg::br_none;
		if (phase == ctrl_pkg::ph_first) begin
			case (live_group)
				isa_pkg::op_brc:  dec.br_kind = ctrl_pkg::br_cond;
				isa_pkg::op_loop: dec.br_kind = ctrl_pkg::br_loop;
				isa_pkg::op_jmp: begin
					case (opcode[3:2])
						isa_pkg::sub_jmp,
						isa_pkg::sub_call: dec.br_kind = ctrl_pkg::br_always;
						isa_pkg::sub_ret:  dec.br_kind = ctrl_pkg::br_return;
						default:           dec.br_kind = ctrl_pkg::br_none; // Old RTI slot
					endcase
				end
				default: dec.br_kind = ctrl_pkg::br_none;
			endcase
		end
	end

endmodule

//--- design/ctrl_pkg.sv
package ctrl_pkg;

	// Register file write data
	typedef enum logic [1:0] {
		wb_src_sp         = 2'd0,
		wb_src_in_port    = 2'd1,
		wb_src_alu_or_mem = 2'd2,
		wb_src_imm        = 2'd3
	} wb_src_t;

	// Data memory write data
	typedef enum logic [1:0] {
		wd_none    = 2'd0,
		wd_rb      = 2'd1,
		wd_pc_next = 2'd2
	} dmem_wd_t;

	// Data memory address
	typedef enum logic [1:0] {
		da_ra         = 2'd0,
		da_sp         = 2'd1,
		da_sp_pre_inc = 2'd2,
		da_ea         = 2'd3  // Second byte of a two-byte instruction
	} dmem_addr_t;

	// Register file write address
	typedef enum logic [1:0] {
		wa_ra     = 2'd0,
		wa_rb     = 2'd1,
		wa_sp     = 2'd2,
		wa_old_rb = 2'd3
	} wb_addr_t;

	typedef enum logic [1:0] {
		pc_plus1     = 2'd0,
		pc_reset_vec = 2'd1,  // M[0]
		pc_target    = 2'd3
	} pc_sel_t;

	typedef enum logic [1:0] {
		ph_boot    = 2'd0,
		ph_first   = 2'd1,
		ph_second  = 2'd2,  // Operand byte of a TWO instruction
		ph_loop_wb = 2'd3   // Write back of the decremented counter
	} phase_t;

	typedef enum logic [2:0] {
		br_none   = 3'd0,
		br_cond   = 3'd1,
		br_always = 3'd2,
		br_loop   = 3'd3,
		br_return = 3'd4
	} branch_kind_t;

	typedef struct packed {
		phase_t            phase;
		isa_pkg::opcode_t  group;
		isa_pkg::sub_op_t  sub_op;
		isa_pkg::reg_idx_t ra;
		isa_pkg::reg_idx_t rb;
		isa_pkg::reg_idx_t old_rb;   // rb of the stored first byte
		branch_kind_t      br_kind;
	} decoded_t;

	typedef struct packed {
		wb_src_t           wb_src;
		dmem_wd_t          dmem_wd;
		dmem_addr_t        dmem_addr;
		wb_addr_t          wb_addr;
		pc_sel_t           pc_sel;
		logic              alu_out;      // 1 ALU, 0 memory
		logic              sp_inc;
		logic              rd2_old_rb;
		logic              out_port_en;
		logic              dmem_we;
		logic              dmem_re;
		logic              regf_we;
		logic              is_ret;
		logic              branch_taken;
		isa_pkg::alu_op_t  alu_op;
		isa_pkg::reg_idx_t old_rb;
	} ctrl_word_t;

	// Everything inactive, PC moves on by one
	localparam ctrl_word_t ctrl_nop = '{
		wb_src: wb_src_sp, dmem_wd: wd_none, dmem_addr: da_ra, wb_addr: wa_ra,
		pc_sel: pc_plus1, alu_out: 1'b0, sp_inc: 1'b0, rd2_old_rb: 1'b0,
		out_port_en: 1'b0, dmem_we: 1'b0, dmem_re: 1'b0, regf_we: 1'b0,
		is_ret: 1'b0, branch_taken: 1'b0, alu_op: isa_pkg::aop_nop, old_rb: 2'b00
	};

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

	typedef logic [7:0] instr_byte_t; // Instruction or immediate byte
	typedef logic [1:0] reg_idx_t;    // One of four registers
	typedef logic [1:0] sub_op_t;     // Bits 3..2, selects within a group
	typedef logic [3:0] flags_t;      // {V, C, N, Z}

	// Upper nibble of the first byte
	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_mov  = 4'd1,
		op_add  = 4'd2,
		op_sub  = 4'd3,
		op_and  = 4'd4,
		op_or   = 4'd5,
		op_rot  = 4'd6,  // RLC RRC SETC CLRC
		op_stk  = 4'd7,  // PUSH POP OUT IN
		op_una  = 4'd8,  // NOT NEG INC DEC
		op_brc  = 4'd9,  // JZ JN JC JV
		op_loop = 4'd10,
		op_jmp  = 4'd11, // JMP CALL RET
		op_two  = 4'd12, // LDM LDD STD
		op_ldi  = 4'd13,
		op_sti  = 4'd14,
		op_rsv  = 4'd15
	} opcode_t;

	// Flag positions, also the sub-op of a conditional branch
	localparam sub_op_t flag_z = 2'd0;
	localparam sub_op_t flag_n = 2'd1;
	localparam sub_op_t flag_c = 2'd2;
	localparam sub_op_t flag_v = 2'd3;

	// Sub-op codes inside each group
	localparam sub_op_t sub_rlc = 2'd0, sub_rrc = 2'd1, sub_setc = 2'd2, sub_clrc = 2'd3;
	localparam sub_op_t sub_push = 2'd0, sub_pop = 2'd1, sub_out = 2'd2, sub_in = 2'd3;
	localparam sub_op_t sub_not = 2'd0, sub_neg = 2'd1, sub_inc = 2'd2, sub_dec = 2'd3;
	localparam sub_op_t sub_jmp = 2'd0, sub_call = 2'd1, sub_ret = 2'd2;
	localparam sub_op_t sub_ldm = 2'd0, sub_ldd = 2'd1, sub_std = 2'd2;

	// ALU operation codes, 26 was RTI
	typedef enum logic [5:0] {
		aop_nop = 6'd0, aop_mov, aop_add, aop_sub,
		aop_and, aop_or, aop_rlc, aop_rrc,
		aop_setc, aop_clrc, aop_push, aop_pop,
		aop_out, aop_in, aop_not, aop_neg,
		aop_inc, aop_dec, aop_jz, aop_jn,
		aop_jc, aop_jv, aop_loop, aop_pass,
		aop_call, aop_ret,
		aop_ldm = 6'd27, aop_ldd, aop_std, aop_ldi,
		aop_sti
	} alu_op_t;

endpackage
